//--- Makefile
TOP  := tb_mrf_tx
SRCS := $(filter %.sv,$(shell cat build.f))

.PHONY: all run clean

all: run

obj_dir/V$(TOP): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- build.f
mrf_pkg.sv
event_port.sv
frame_sequencer.sv
enc_8b10b.sv
mrf_tx_top.sv
tb_mrf_tx.sv

//--- enc_8b10b.sv
module enc_8b10b (
    input  logic                tx_clk,
    input  logic                reset,
    input  logic                word_valid,
    input  logic                k_hi,
    input  logic                k_lo,
    input  mrf_pkg::byte_t      word_hi,
    input  mrf_pkg::byte_t      word_lo,
    output mrf_pkg::code_word_t symbols
);

    logic             rd;          // Running disparity with 1 as positive
    logic             rd_start;
    logic             rd_mid;      // After the high symbol
    logic             rd_next;     // After the low symbol
    mrf_pkg::symbol_t sym_hi;
    mrf_pkg::symbol_t sym_lo;

    // 5b/6b codes as sent with RD-
    function automatic logic [5:0] code_6b(input logic [4:0] x);
        case (x)
            5'd0:    return 6'b100111;
            5'd1:    return 6'b011101;
            5'd2:    return 6'b101101;
            5'd3:    return 6'b110001;
            5'd4:    return 6'b110101;
            5'd5:    return 6'b101001;
            5'd6:    return 6'b011001;
            5'd7:    return 6'b111000;
            5'd8:    return 6'b111001;
            5'd9:    return 6'b100101;
            5'd10:   return 6'b010101;
            5'd11:   return 6'b110100;
            5'd12:   return 6'b001101;
            5'd13:   return 6'b101100;
            5'd14:   return 6'b011100;
            5'd15:   return 6'b010111;
            5'd16:   return 6'b011011;
            5'd17:   return 6'b100011;
            5'd18:   return 6'b010011;
            5'd19:   return 6'b110010;
            5'd20:   return 6'b001011;
            5'd21:   return 6'b101010;
            5'd22:   return 6'b011010;
            5'd23:   return 6'b111010;
            5'd24:   return 6'b110011;
            5'd25:   return 6'b100110;
            5'd26:   return 6'b010110;
            5'd27:   return 6'b110110;
            5'd28:   return 6'b001110;
            5'd29:   return 6'b101110;
            5'd30:   return 6'b011110;
            default: return 6'b101011;
        endcase
    endfunction

    // 3b/4b codes as sent with RD-
    function automatic logic [3:0] code_4b(input logic [2:0] y, input logic alt7);
        case (y)
            3'd0:    return 4'b1011;
            3'd1:    return 4'b1001;
            3'd2:    return 4'b0101;
            3'd3:    return 4'b1100;
            3'd4:    return 4'b1101;
            3'd5:    return 4'b1010;
            3'd6:    return 4'b0110;
            default: return alt7 ? 4'b0111 : 4'b1110;   // A7 avoids a run of five
        endcase
    endfunction

    // One byte with the disparity it enters and leaves with
    function automatic mrf_pkg::symbol_t enc_byte(
        input  mrf_pkg::byte_t b,
        input  logic           k,
        input  logic           rd_in,
        output logic           rd_out
    );
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd_6b;
        logic       alt7;
        logic [4:0] x;

        x = b[4:0];
        if (k && (b == mrf_pkg::K28_5))
        begin
            rd_out = !rd_in;        // Comma is unbalanced in the 6b part
            return rd_in ? mrf_pkg::K28_5_RDP : mrf_pkg::K28_5_RDN;
        end
        c6    = code_6b(x);
        rd_6b = ($countones(c6) != 3) ? !rd_in : rd_in;
        if (rd_in && (($countones(c6) != 3) || (x == 5'd7)))
        begin
            c6 = ~c6;               // RD+ form including D.07
        end
        alt7 = (!rd_6b && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
               (rd_6b && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14)));
        c4     = code_4b(b[7:5], alt7);
        rd_out = ($countones(c4) != 2) ? !rd_6b : rd_6b;
        if (rd_6b && (($countones(c4) != 2) || (b[7:5] == 3'd3)))
        begin
            c4 = ~c4;               // RD+ form including D.x.3
        end
        return {c6, c4};
    endfunction

    // Disparity chains high, low, then the next word
    always_comb
    begin
        rd_start = word_valid ? rd : 1'b0;   // Idle words start from RD-
        sym_hi   = enc_byte(word_hi, k_hi, rd_start, rd_mid);
        sym_lo   = enc_byte(word_lo, k_lo, rd_mid, rd_next);
    end

    always_ff @(posedge tx_clk)
    begin
        if (reset)
        begin
            rd <= 1'b0;
        end
        else
        begin
            rd <= word_valid ? rd_next : 1'b0;
        end
    end

    always_ff @(posedge tx_clk)
    begin
        symbols <= {sym_hi, sym_lo};    // High symbol first on the wire
    end

    // The sequencer flags only commas as K
    a_k_is_comma: assert property (@(posedge tx_clk) disable iff (reset)
        (!k_hi || (word_hi == mrf_pkg::K28_5)) && (!k_lo || (word_lo == mrf_pkg::K28_5)));

endmodule

//--- event_port.sv
module event_port (
    input  logic           tx_clk,
    input  logic           reset,
    input  logic           evt_req,
    input  logic           evt_take,
    input  mrf_pkg::byte_t evt_code,
    output logic           evt_ack,
    output logic           evt_pending,
    output mrf_pkg::byte_t evt_head
);

    mrf_pkg::hs_state_t state;
    mrf_pkg::byte_t     fifo_mem [mrf_pkg::EVT_FIFO_DEPTH];
    mrf_pkg::evt_ptr_t  wr_ptr;
    mrf_pkg::evt_ptr_t  rd_ptr;
    mrf_pkg::evt_cnt_t  count;
    logic               fifo_full;
    logic               wr_en;

    // Circular pointer step
    function automatic mrf_pkg::evt_ptr_t ptr_inc(input mrf_pkg::evt_ptr_t p);
        if (p == mrf_pkg::evt_ptr_t'(mrf_pkg::EVT_FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign fifo_full   = (count == mrf_pkg::evt_cnt_t'(mrf_pkg::EVT_FIFO_DEPTH));
    assign wr_en       = (state == mrf_pkg::IDLE) && evt_req && !fifo_full; // Accepting edge
    assign evt_ack     = (state != mrf_pkg::IDLE);
    assign evt_pending = (count != '0);
    assign evt_head    = fifo_mem[rd_ptr];  // Oldest entry

    // Four-phase handshake
    // A full queue keeps us in IDLE, so ack stays low
    always_ff @(posedge tx_clk)
    begin
        if (reset)
        begin
            state <= mrf_pkg::IDLE;
        end
        else
        begin
            case (state)
                mrf_pkg::IDLE:
                begin
                    if (wr_en)
                    begin
                        state <= mrf_pkg::ACK;
                    end
                end
                mrf_pkg::ACK:
                begin
                    state <= evt_req ? mrf_pkg::WAIT_LOW : mrf_pkg::IDLE;
                end
                mrf_pkg::WAIT_LOW:
                begin
                    if (!evt_req)
                    begin
                        state <= mrf_pkg::IDLE;     // Ack drops here
                    end
                end
                default: state <= mrf_pkg::IDLE;
            endcase
        end
    end

    // Queue pointers and fill level
    always_ff @(posedge tx_clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (evt_take)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, evt_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge tx_clk)
    begin
        if (wr_en)
        begin
            fifo_mem[wr_ptr] <= evt_code;
        end
    end

    // Ack only answers a request seen on the edge before
    a_ack_needs_req: assert property (@(posedge tx_clk) disable iff (reset)
        $rose(evt_ack) |-> $past(evt_req));

    // A write into a full queue would push the fill level past the depth
    a_no_write_full: assert property (@(posedge tx_clk) disable iff (reset)
        count <= mrf_pkg::evt_cnt_t'(mrf_pkg::EVT_FIFO_DEPTH));

    // Sequencer pops only what is there
    a_take_needs_entry: assert property (@(posedge tx_clk) disable iff (reset)
        evt_take |-> evt_pending);

endmodule

//--- frame_sequencer.sv
module frame_sequencer (
    input  logic           tx_clk,
    input  logic           reset,
    input  logic           link_ready,
    input  logic           evt_pending,
    input  mrf_pkg::byte_t evt_head,
    input  mrf_pkg::byte_t dbus,
    output logic           evt_take,
    output logic           k_hi,
    output logic           k_lo,
    output logic           word_valid,
    output mrf_pkg::byte_t word_hi,
    output mrf_pkg::byte_t word_lo
);

    mrf_pkg::comma_idx_t word_idx;     // Index of the word built on the next edge
    logic                comma_slot;

    // Slot 0 of every period is reserved for the comma
    assign comma_slot = (word_idx == '0);

    // Pop the head whenever a free high-byte slot goes out
    assign evt_take = link_ready && !comma_slot && evt_pending;

    always_ff @(posedge tx_clk)
    begin
        if (reset)
        begin
            word_idx   <= '0;
            word_hi    <= mrf_pkg::K28_5;
            word_lo    <= mrf_pkg::K28_5;
            k_hi       <= 1'b1;
            k_lo       <= 1'b1;
            word_valid <= 1'b0;
        end
        else if (!link_ready)
        begin
            // Link down, idle commas and the schedule restarts
            word_idx   <= '0;
            word_hi    <= mrf_pkg::K28_5;
            word_lo    <= mrf_pkg::K28_5;
            k_hi       <= 1'b1;
            k_lo       <= 1'b1;
            word_valid <= 1'b0;
        end
        else
        begin
            if (word_idx == mrf_pkg::comma_idx_t'(mrf_pkg::COMMA_PERIOD - 1))
            begin
                word_idx <= '0;
            end
            else
            begin
                word_idx <= word_idx + 1'b1;
            end
            word_valid <= 1'b1;
            word_lo    <= dbus;             // Distributed bus, plain data
            k_lo       <= 1'b0;
            if (evt_take)
            begin
                word_hi <= evt_head;        // Event code
                k_hi    <= 1'b0;
            end
            else
            begin
                word_hi <= mrf_pkg::K28_5;  // Forced or filler comma
                k_hi    <= 1'b1;
            end
        end
    end

    // Comma slot always leaves as a K character
    a_comma_slot: assert property (@(posedge tx_clk) disable iff (reset)
        (link_ready && comma_slot) |=> k_hi);

endmodule

//--- mrf_pkg.sv
package mrf_pkg;

    // One byte of the 16-bit link word
    typedef logic [7:0] byte_t;

    // 8b/10b symbol, abcdei in [9:4] and fghj in [3:0]
    typedef logic [9:0] symbol_t;

    // High byte's symbol sits in [19:10]
    typedef logic [19:0] code_word_t;

    // Event queue
    localparam int EVT_FIFO_DEPTH = 4;
    localparam int EVT_PTR_W      = $clog2(EVT_FIFO_DEPTH);

    typedef logic [EVT_PTR_W-1:0] evt_ptr_t;
    typedef logic [EVT_PTR_W:0]   evt_cnt_t;    // Counts 0 up to full depth

    // Forced comma schedule
    localparam int COMMA_PERIOD = 8;            // Words per comma slot
    localparam int COMMA_IDX_W  = $clog2(COMMA_PERIOD);

    typedef logic [COMMA_IDX_W-1:0] comma_idx_t;

    // Comma byte and its two encodings
    localparam byte_t   K28_5     = 8'hBC;
    localparam symbol_t K28_5_RDN = 10'b001111_1010;   // Entered with RD-
    localparam symbol_t K28_5_RDP = 10'b110000_0101;   // Entered with RD+

    // Host handshake states
    typedef enum logic [1:0] {
        IDLE,       // Ack low, waiting for a request
        ACK,        // Code taken on the last edge
        WAIT_LOW    // Ack held until req drops
    } hs_state_t;

endpackage

//--- mrf_tx_top.sv
module mrf_tx_top (
    input  logic                tx_clk,
    input  logic                reset,
    input  logic                link_ready,     // Transceiver TX reset done
    input  logic                evt_req,
    input  mrf_pkg::byte_t      evt_code,
    input  mrf_pkg::byte_t      dbus,
    output logic                evt_ack,
    output mrf_pkg::code_word_t symbols         // To the transceiver
);

    logic           evt_take;
    logic           evt_pending;
    mrf_pkg::byte_t evt_head;
    logic           k_hi;
    logic           k_lo;
    logic           word_valid;
    mrf_pkg::byte_t word_hi;
    mrf_pkg::byte_t word_lo;

    // Host side, handshake and queue
    event_port event_port_i (
        .tx_clk      (tx_clk),
        .reset       (reset),
        .evt_req     (evt_req),
        .evt_take    (evt_take),
        .evt_code    (evt_code),
        .evt_ack     (evt_ack),
        .evt_pending (evt_pending),
        .evt_head    (evt_head)
    );

    // One word per tx_clk
    frame_sequencer frame_sequencer_i (
        .tx_clk      (tx_clk),
        .reset       (reset),
        .link_ready  (link_ready),
        .evt_pending (evt_pending),
        .evt_head    (evt_head),
        .dbus        (dbus),
        .evt_take    (evt_take),
        .k_hi        (k_hi),
        .k_lo        (k_lo),
        .word_valid  (word_valid),
        .word_hi     (word_hi),
        .word_lo     (word_lo)
    );

    enc_8b10b enc_8b10b_i (
        .tx_clk      (tx_clk),
        .reset       (reset),
        .word_valid  (word_valid),
        .k_hi        (k_hi),
        .k_lo        (k_lo),
        .word_hi     (word_hi),
        .word_lo     (word_lo),
        .symbols     (symbols)
    );

endmodule

//--- tb_mrf_tx.sv
module tb_mrf_tx;

    localparam int          N_EVENTS     = 200;
    localparam int          BURST_START  = 100;   // Zero-gap burst while the link is down
    localparam int          BURST_LEN    = 40;
    localparam int          COMMA_PERIOD = 8;
    localparam logic [7:0]  K_BYTE       = 8'hBC;

    logic                tx_clk;
    logic                reset;
    logic                link_ready;
    logic                evt_req;
    mrf_pkg::byte_t      evt_code;
    mrf_pkg::byte_t      dbus;
    logic                evt_ack;
    mrf_pkg::code_word_t symbols;

    // RD- forms of the 5b/6b and 3b/4b codes
    logic [5:0] tab_6b [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
    logic [3:0] tab_4b [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};

    // Reference model state
    logic       m_ack      = 1'b0;
    logic [7:0] fifo_q[$];                 // Acknowledged, not yet sent
    int         m_idx      = 0;
    logic [7:0] w_hi       = K_BYTE;       // Word register
    logic [7:0] w_lo       = K_BYTE;
    logic       w_khi      = 1'b1;
    logic       w_klo      = 1'b1;
    logic       w_valid    = 1'b0;
    logic       m_rd       = 1'b0;         // 1 is RD+
    logic [19:0] exp_sym   = '0;
    logic       live       = 1'b0;
    logic       word_known = 1'b0;
    int         taken      = 0;
    int         full_seen  = 0;
    int         offered    = 0;
    logic       host_done  = 1'b0;

    mrf_tx_top mrf_tx_top_i (
        .tx_clk     (tx_clk),
        .reset      (reset),
        .link_ready (link_ready),
        .evt_req    (evt_req),
        .evt_code   (evt_code),
        .dbus       (dbus),
        .evt_ack    (evt_ack),
        .symbols    (symbols)
    );

    task automatic halt_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        halt_run();
    endtask

    task automatic report_msg(input string msg);
        $display("%s", msg);
        halt_run();
    endtask

    // Returns {rd_out, abcdei, fghj}
    function automatic logic [10:0] ref_encode(input logic [7:0] b, input logic k,
                                               input logic rd_in);
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd_mid;
        logic       rd_out;

        if (k)
        begin
            return rd_in ? {1'b0, 10'b110000_0101} : {1'b1, 10'b001111_1010};  // K28.5
        end
        c6     = tab_6b[b[4:0]];
        rd_mid = rd_in ^ ($countones(c6) != 3);     // Unbalanced block flips RD
        if (rd_in && (($countones(c6) != 3) || (b[4:0] == 5'd7)))
        begin
            c6 = ~c6;
        end
        c4     = tab_4b[b[7:5]];
        rd_out = rd_mid ^ ($countones(c4) != 2);
        if (rd_mid && (($countones(c4) != 2) || (b[7:5] == 3'd3)))
        begin
            c4 = ~c4;
        end
        // Primary x.7 would make five equal bits across e i f g h
        if ((b[7:5] == 3'd7) && (c6[1:0] == {2{c4[3]}}))
        begin
            c4 = {c4[0], c4[3:1]};                  // Alternate A7
        end
        return {rd_out, c6, c4};
    endfunction

    initial
    begin
        tx_clk = 1'b0;
        forever #5 tx_clk = ~tx_clk;
    end

    // Cycle model sampling before the DUT's edge updates land
    always @(posedge tx_clk)
    begin : model_step
        logic        take;
        logic        accept;
        logic        rd_start;
        logic [10:0] e_hi;
        logic [10:0] e_lo;

        if (live)
        begin
            assert (evt_ack === m_ack)
                else report_value("evt_ack", 32'(evt_ack), 32'(m_ack));
            assert (symbols[19:10] === exp_sym[19:10])
                else report_value("symbols[19:10]", 32'(symbols[19:10]), 32'(exp_sym[19:10]));
            assert (symbols[9:0] === exp_sym[9:0])
                else report_value("symbols[9:0]", 32'(symbols[9:0]), 32'(exp_sym[9:0]));
        end
        rd_start = w_valid ? m_rd : 1'b0;           // Idle words restart at RD-
        e_hi     = ref_encode(w_hi, w_khi, rd_start);
        e_lo     = ref_encode(w_lo, w_klo, e_hi[10]);
        exp_sym  = {e_hi[9:0], e_lo[9:0]};
        if (reset)
        begin
            live       = word_known;                // Word register known after one edge
            word_known = 1'b1;
            m_ack      = 1'b0;
            fifo_q.delete();
            m_idx      = 0;
            m_rd       = 1'b0;
            w_hi       = K_BYTE;
            w_lo       = K_BYTE;
            w_khi      = 1'b1;
            w_klo      = 1'b1;
            w_valid    = 1'b0;
        end
        else
        begin
            m_rd   = w_valid ? e_lo[10] : 1'b0;
            take   = link_ready && (m_idx != 0) && (fifo_q.size() != 0);
            accept = !m_ack && evt_req && (fifo_q.size() < mrf_pkg::EVT_FIFO_DEPTH);
            if (!m_ack && evt_req && !accept)
            begin
                full_seen++;                        // Request held off by a full queue
            end
            if (!link_ready)
            begin
                m_idx   = 0;
                w_hi    = K_BYTE;
                w_lo    = K_BYTE;
                w_khi   = 1'b1;
                w_klo   = 1'b1;
                w_valid = 1'b0;
            end
            else
            begin
                w_valid = 1'b1;
                w_lo    = dbus;
                w_klo   = 1'b0;
                if (take)
                begin
                    w_hi  = fifo_q.pop_front();     // Oldest code
                    w_khi = 1'b0;
                    taken++;
                end
                else
                begin
                    w_hi  = K_BYTE;
                    w_khi = 1'b1;
                end
                m_idx = (m_idx + 1) % COMMA_PERIOD;
            end
            if (accept)
            begin
                fifo_q.push_back(evt_code);
            end
            m_ack = m_ack ? evt_req : accept;       // Ack follows req down
        end
    end

    initial
    begin
        dbus = '0;
        forever
        begin
            @(posedge tx_clk);
            dbus <= 8'($urandom);
        end
    end

    // One four-phase transfer entered and left on a rising edge
    task automatic offer_event(input logic [7:0] code);
        evt_code <= code;
        evt_req  <= 1'b1;
        do
            @(posedge tx_clk);
        while (evt_ack !== 1'b1);
        evt_req <= 1'b0;
        do
            @(posedge tx_clk);
        while (evt_ack !== 1'b0);
    endtask

    // Host
    initial
    begin
        int gap;

        evt_req  = 1'b0;
        evt_code = '0;
        repeat (8) @(posedge tx_clk);
        for (int i = 0; i < N_EVENTS; i++)
        begin
            gap = ((i >= BURST_START) && (i < BURST_START + BURST_LEN)) ? 0
                                                                        : $urandom_range(7, 0);
            repeat (gap) @(posedge tx_clk);
            offer_event(8'($urandom));
            offered = i + 1;
        end
        host_done = 1'b1;
    end

    initial
    begin
        repeat (40 * N_EVENTS + 1000) @(posedge tx_clk);
        report_msg("Timeout before all events were sent");
    end

    initial
    begin
        void'($urandom(29));
        reset      = 1'b1;
        link_ready = 1'b0;
        repeat (5) @(posedge tx_clk);
        reset <= 1'b0;
        repeat (6) @(posedge tx_clk);
        link_ready <= 1'b1;
        while (offered < BURST_START)
        begin
            @(posedge tx_clk);
        end
        link_ready <= 1'b0;                         // Link drop lets the queue fill up
        repeat (60) @(posedge tx_clk);
        link_ready <= 1'b1;
        while (!host_done)
        begin
            @(posedge tx_clk);
        end
        repeat (3 * COMMA_PERIOD) @(posedge tx_clk);    // Queue drains through the encoder
        assert (fifo_q.size() == 0)
            else report_msg("Acknowledged events left unsent at end of run");
        assert (taken == N_EVENTS)
            else report_value("taken", 32'(taken), 32'(N_EVENTS));
        assert (full_seen > 0)
            else report_msg("Event queue never filled during the burst");
        $display(">>> PASS");
        $finish;
    end

endmodule
